/* hdl/exu_pkg.sv */
`default_nettype none

package exu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t; // rv32e, 16 regs
	typedef logic [3:0]  wmask_t;
	typedef logic [2:0]  funct3_t;

	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_op_imm,
		cls_op,
		cls_system,
		cls_illegal
	} inst_class_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_xor,
		alu_or,
		alu_srl,
		alu_sra,
		alu_sll,
		alu_slt,
		alu_sltu
	} alu_op_e;

	// major opcodes, inst[6:0]
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_system = 7'b1110011;

	localparam word_t inst_len = 32'd4; // pc step

endpackage

`default_nettype wire

/* hdl/decoded_if.sv */
`default_nettype none

interface decoded_if;
	import exu_pkg::*;

	inst_class_e inst_class;
	alu_op_e     alu_op;
	word_t       imm;
	reg_idx_t    rd;
	funct3_t     funct3;
	logic        reg_wen;
	logic [11:0] csr_addr;
	logic        ecall;
	logic        mret;

	modport dec (
		output inst_class, alu_op, imm, rd, funct3, reg_wen, csr_addr, ecall, mret
	);

	modport exe (
		input inst_class, alu_op, imm, rd, funct3, reg_wen, csr_addr, ecall, mret
	);

endinterface

`default_nettype wire

/* hdl/exec_if.sv */
`default_nettype none

interface exec_if;
	import exu_pkg::*;

	word_t       val;
	word_t       jump_addr;
	logic        redirect;
	word_t       csr_wdata;
	logic        csr_en;
	wmask_t      wmask;
	word_t       store_data;
	logic        load_en, store_en, link_en;
	logic        reg_wen, ecall;
	reg_idx_t    rd;
	funct3_t     funct3;
	logic [11:0] csr_addr;

	modport exe (output val, jump_addr, redirect, csr_wdata, csr_en, wmask, store_data,
		load_en, store_en, link_en, reg_wen, ecall, rd, funct3, csr_addr);

	modport res (input val, jump_addr, redirect, csr_wdata, csr_en, wmask, store_data,
		load_en, store_en, link_en, reg_wen, ecall, rd, funct3, csr_addr);

endinterface

`default_nettype wire

/* hdl/inst_decode.sv */
`default_nettype none

module inst_decode (
	input wire exu_pkg::word_t inst,
	decoded_if.dec             dec
);
	import exu_pkg::*;

	logic [6:0] opcode;
	logic       f7_b5;

	assign opcode = inst[6:0];
	assign f7_b5  = inst[30];

	assign dec.rd       = inst[10:7]; // top bit of rd dropped for rv32e
	assign dec.funct3   = inst[14:12];
	assign dec.csr_addr = inst[31:20];
	assign dec.ecall    = (inst == 32'h0000_0073);
	assign dec.mret     = (inst == 32'h3020_0073);

	always_comb begin
		case (opcode)
			opc_lui:    dec.inst_class = cls_lui;
			opc_auipc:  dec.inst_class = cls_auipc;
			opc_jal:    dec.inst_class = cls_jal;
			opc_jalr:   dec.inst_class = cls_jalr;
			opc_branch: dec.inst_class = cls_branch;
			opc_load:   dec.inst_class = cls_load;
			opc_store:  dec.inst_class = cls_store;
			opc_op_imm: dec.inst_class = cls_op_imm;
			opc_op:     dec.inst_class = cls_op;
			opc_system: dec.inst_class = cls_system;
			default:    dec.inst_class = cls_illegal;
		endcase
	end

	// immediate format and rd write enable per class
	always_comb begin
		dec.imm     = {{20{inst[31]}}, inst[31:20]}; // I type
		dec.reg_wen = 1'b0;
		case (dec.inst_class)
			cls_lui, cls_auipc: begin
				dec.imm     = {inst[31:12], 12'b0};
				dec.reg_wen = 1'b1;
			end
			cls_jal: begin
				dec.imm     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				dec.reg_wen = 1'b1;
			end
			cls_branch: dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			cls_store:  dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			cls_jalr, cls_load, cls_op_imm, cls_op: dec.reg_wen = 1'b1;
			cls_system: dec.reg_wen = (inst[14:12] != 3'b000); // csr ops only
			default: ;
		endcase
	end

	always_comb begin
		dec.alu_op = alu_add;
		if (dec.inst_class == cls_op || dec.inst_class == cls_op_imm) begin
			case (inst[14:12])
				3'b000:  dec.alu_op = (dec.inst_class == cls_op && f7_b5) ? alu_sub : alu_add;
				3'b001:  dec.alu_op = alu_sll;
				3'b010:  dec.alu_op = alu_slt;
				3'b011:  dec.alu_op = alu_sltu;
				3'b100:  dec.alu_op = alu_xor;
				3'b101:  dec.alu_op = f7_b5 ? alu_sra : alu_srl;
				3'b110:  dec.alu_op = alu_or;
				default: dec.alu_op = alu_and;
			endcase
		end
	end

	always_comb begin
		assert final (!(dec.inst_class == cls_illegal && dec.reg_wen))
			else $error("illegal instruction flagged as register write");
	end

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`default_nettype none

module exec_unit (
	input wire exu_pkg::word_t pc,
	input wire exu_pkg::word_t src1,
	input wire exu_pkg::word_t src2,
	input wire exu_pkg::word_t csr_val,
	input wire exu_pkg::word_t csr_jump,
	input wire                 csr_jump_en,
	decoded_if.exe             dec,
	exec_if.exe                ex
);
	import exu_pkg::*;

	word_t    lop, rop;
	word_t    sum, snpc, target, next_pc;
	logic [4:0] shamt;
	logic     take_br, jump_en;
	logic     is_jal, is_jalr, is_br;

	assign is_jal  = (dec.inst_class == cls_jal);
	assign is_jalr = (dec.inst_class == cls_jalr);
	assign is_br   = (dec.inst_class == cls_branch);

	assign lop = (dec.inst_class == cls_auipc || is_jal || is_br) ? pc :
		(dec.inst_class == cls_lui) ? '0 : src1;
	assign rop = (dec.inst_class == cls_op) ? src2 : dec.imm;

	assign sum   = lop + rop;
	assign shamt = rop[4:0];

	always_comb begin
		case (dec.alu_op)
			alu_sub:  ex.val = lop - rop;
			alu_and:  ex.val = lop & rop;
			alu_xor:  ex.val = lop ^ rop;
			alu_or:   ex.val = lop | rop;
			alu_srl:  ex.val = lop >> shamt;
			alu_sra:  ex.val = $signed(lop) >>> shamt;
			alu_sll:  ex.val = lop << shamt;
			alu_slt:  ex.val = {31'b0, $signed(lop) < $signed(rop)};
			alu_sltu: ex.val = {31'b0, lop < rop};
			default:  ex.val = sum;
		endcase
	end

	// branch compare always on the register operands
	always_comb begin
		case (dec.funct3)
			3'b000:  take_br = (src1 == src2);
			3'b001:  take_br = (src1 != src2);
			3'b100:  take_br = $signed(src1) < $signed(src2);
			3'b101:  take_br = $signed(src1) >= $signed(src2);
			3'b110:  take_br = src1 < src2;
			3'b111:  take_br = src1 >= src2;
			default: take_br = 1'b0;
		endcase
	end

	assign jump_en = is_jal || is_jalr || (is_br && take_br);
	assign target  = is_jalr ? {sum[31:1], 1'b0} : sum;
	assign snpc    = pc + inst_len;
	assign next_pc = csr_jump_en ? csr_jump : jump_en ? target : snpc;

	assign ex.jump_addr = next_pc;
	assign ex.redirect  = (next_pc != snpc);

	assign ex.csr_wdata = (dec.funct3 == 3'b001) ? src1 :
		(dec.funct3 == 3'b010) ? (src1 | csr_val) : '0;
	// ecall/mret go through the csr unit redirect, not a csr write
	assign ex.csr_en = (dec.inst_class == cls_system) && (dec.funct3 != 3'b000)
		&& !(dec.ecall || dec.mret);

	assign ex.wmask = (dec.funct3[1:0] == 2'b00) ? 4'h1 :
		(dec.funct3[1:0] == 2'b01) ? 4'h3 : 4'hf;
	assign ex.store_data = src2;
	assign ex.load_en    = (dec.inst_class == cls_load);
	assign ex.store_en   = (dec.inst_class == cls_store);
	assign ex.link_en    = is_jal || is_jalr;

	assign ex.reg_wen  = dec.reg_wen;
	assign ex.ecall    = dec.ecall;
	assign ex.rd       = dec.rd;
	assign ex.funct3   = dec.funct3;
	assign ex.csr_addr = dec.csr_addr;

	always_comb begin
		assert final (!(ex.load_en && ex.store_en)) else $error("load and store both set");
	end

endmodule

`default_nettype wire

/* hdl/result_buffer.sv */
`default_nettype none

module result_buffer (
	input wire                   clock,
	input wire                   rst_n,
	input wire                   in_valid,
	output logic                 in_ready,
	output logic                 out_valid,
	input wire                   out_ready,
	exec_if.res                  ex,
	input wire exu_pkg::word_t   pc,
	output exu_pkg::word_t       val,
	output exu_pkg::word_t       jump_addr,
	output exu_pkg::word_t       csr_wdata,
	output exu_pkg::word_t       store_data,
	output exu_pkg::word_t       pc_out,
	output exu_pkg::wmask_t      wmask,
	output exu_pkg::reg_idx_t    rd,
	output exu_pkg::funct3_t     funct3,
	output logic [11:0]          csr_addr,
	output logic                 redirect,
	output logic                 reg_wen,
	output logic                 load_en,
	output logic                 store_en,
	output logic                 csr_en,
	output logic                 link_en,
	output logic                 ecall
);

	logic in_fire, out_fire;
	logic redirect_q;

	assign in_fire  = in_valid && in_ready;
	assign out_fire = out_valid && out_ready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			in_ready  <= 1'b1;
			out_valid <= 1'b0;
		end else begin
			in_ready  <= (in_ready && !in_valid) || out_fire;
			out_valid <= (out_valid && !out_ready) || in_fire;
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		if (in_fire) begin
			val        <= ex.val;
			jump_addr  <= ex.jump_addr;
			redirect_q <= ex.redirect;
			csr_wdata  <= ex.csr_wdata;
			store_data <= ex.store_data;
			pc_out     <= pc;
			wmask      <= ex.wmask;
			rd         <= ex.rd;
			funct3     <= ex.funct3;
			csr_addr   <= ex.csr_addr;
			reg_wen    <= ex.reg_wen;
			load_en    <= ex.load_en;
			store_en   <= ex.store_en;
			csr_en     <= ex.csr_en;
			link_en    <= ex.link_en;
			ecall      <= ex.ecall;
		end
	end

	assign redirect = out_valid && redirect_q; // no stale flush

	assert property (@(posedge clock) disable iff (!rst_n) !(in_ready && out_valid))
		else $error("in_ready and out_valid both high");

	assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable({val, jump_addr, redirect,
		csr_wdata, store_data, pc_out, wmask, rd, funct3, csr_addr, reg_wen, load_en,
		store_en, csr_en, link_en, ecall}))
		else $error("outputs changed under back-pressure");

endmodule

`default_nettype wire

/* hdl/exu_top.sv */
`default_nettype none

module exu_top (
	input wire                 clock,
	input wire                 rst_n,
	input wire                 in_valid,
	output logic               in_ready,
	input wire exu_pkg::word_t inst,
	input wire exu_pkg::word_t pc,
	input wire exu_pkg::word_t src1,
	input wire exu_pkg::word_t src2,
	input wire exu_pkg::word_t csr_val,
	input wire                 csr_jump_en,
	input wire exu_pkg::word_t csr_jump,
	output logic               out_valid,
	input wire                 out_ready,
	output exu_pkg::word_t     val,
	output exu_pkg::word_t     jump_addr,
	output exu_pkg::word_t     csr_wdata,
	output exu_pkg::word_t     store_data,
	output exu_pkg::word_t     pc_out,
	output exu_pkg::wmask_t    wmask,
	output exu_pkg::reg_idx_t  rd,
	output exu_pkg::funct3_t   funct3,
	output logic [11:0]        csr_addr,
	output logic               redirect,
	output logic               reg_wen,
	output logic               load_en,
	output logic               store_en,
	output logic               csr_en,
	output logic               link_en,
	output logic               ecall
);

	decoded_if dec_bus ();
	exec_if    ex_bus ();

	inst_decode u_decode (.inst(inst), .dec(dec_bus.dec));

	exec_unit u_exec (
		.pc(pc), .src1(src1), .src2(src2), .csr_val(csr_val),
		.csr_jump(csr_jump), .csr_jump_en(csr_jump_en),
		.dec(dec_bus.exe), .ex(ex_bus.exe)
	);

	result_buffer u_result (
		.clock(clock), .rst_n(rst_n),
		.in_valid(in_valid), .in_ready(in_ready),
		.out_valid(out_valid), .out_ready(out_ready),
		.ex(ex_bus.res), .pc(pc),
		.val(val), .jump_addr(jump_addr), .csr_wdata(csr_wdata),
		.store_data(store_data), .pc_out(pc_out), .wmask(wmask),
		.rd(rd), .funct3(funct3), .csr_addr(csr_addr), .redirect(redirect),
		.reg_wen(reg_wen), .load_en(load_en), .store_en(store_en),
		.csr_en(csr_en), .link_en(link_en), .ecall(ecall)
	);

endmodule

`default_nettype wire

/* tests/exu_ref_model.svh */
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

typedef struct packed {
	word_t       val;
	word_t       jump_addr;
	word_t       csr_wdata;
	word_t       store_data;
	word_t       pc_out;
	wmask_t      wmask;
	reg_idx_t    rd;
	funct3_t     funct3;
	logic [11:0] csr_addr;
	logic        redirect;
	logic        reg_wen;
	logic        load_en;
	logic        store_en;
	logic        csr_en;
	logic        link_en;
	logic        ecall;
} expect_t;

word_t lfsr = 32'hb601;

// taps 32 22 2 1
function automatic word_t lfsr_next(input word_t s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_bits(input int n, output word_t r);
	r = '0;
	for (int k = 0; k < n; k++) begin
		lfsr = lfsr_next(lfsr);
		r = {r[30:0], lfsr[0]}; // one step per bit
	end
endtask

function automatic word_t alu_model(input funct3_t f3, input logic alt, input word_t a,
	input word_t b);
	logic [4:0] sh;
	sh = b[4:0];
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << sh;
		3'd2: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: return (alt && a[31]) ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh);
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
	logic lt;
	lt = (a[31] != b[31]) ? a[31] : (a < b); // signed less than
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return lt;
		3'd5: return !lt;
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic expect_t model_expect(input word_t inst, pc, a, b, cv,
	input logic cj_en, input word_t cj);
	expect_t    e;
	funct3_t    f3;
	logic [6:0] op;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j, tgt;
	logic       jmp;
	f3    = inst[14:12];
	op    = inst[6:0];
	imm_i = {{20{inst[31]}}, inst[31:20]};
	imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	imm_u = {inst[31:12], 12'h000};
	imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	e = '0;
	e.rd         = inst[10:7];
	e.funct3     = f3;
	e.csr_addr   = inst[31:20];
	e.pc_out     = pc;
	e.store_data = b;
	e.wmask      = (f3[1:0] == 2'd0) ? 4'h1 : (f3[1:0] == 2'd1) ? 4'h3 : 4'hf;
	e.csr_wdata  = (f3 == 3'd1) ? a : (f3 == 3'd2) ? (a | cv) : '0;
	e.load_en    = (op == opc_load);
	e.store_en   = (op == opc_store);
	e.link_en    = (op == opc_jal) || (op == opc_jalr);
	e.csr_en     = (op == opc_system) && (f3 != 3'd0);
	e.ecall      = (inst == 32'h0000_0073);
	e.reg_wen    = (op == opc_system) ? (f3 != 3'd0) : (op != opc_branch && op != opc_store);
	case (op)
		opc_lui:    e.val = imm_u;
		opc_auipc:  e.val = pc + imm_u;
		opc_jal:    e.val = pc + imm_j;
		opc_branch: e.val = pc + imm_b;
		opc_store:  e.val = a + imm_s;
		opc_op_imm: e.val = alu_model(f3, inst[30] && f3 == 3'd5, a, imm_i);
		opc_op:     e.val = alu_model(f3, inst[30], a, b);
		default:    e.val = a + imm_i; // jalr, load, system
	endcase
	jmp = e.link_en || (op == opc_branch && branch_taken(f3, a, b));
	tgt = (op == opc_jalr) ? {e.val[31:1], 1'b0} : e.val;
	e.jump_addr = cj_en ? cj : jmp ? tgt : pc + 32'd4;
	e.redirect  = (e.jump_addr != pc + 32'd4);
	return e;
endfunction

`endif

/* tests/tb_exu.sv */
`default_nettype none

module tb_exu;
	import exu_pkg::*;

	localparam int n_inst    = 400;
	localparam int max_cycle = 16 * n_inst + 100;

	logic        clock = 1'b0;
	logic        rst_n;
	logic        in_valid, in_ready, out_valid, out_ready;
	word_t       inst, pc, src1, src2, csr_val, csr_jump;
	logic        csr_jump_en;
	word_t       val, jump_addr, csr_wdata, store_data, pc_out;
	wmask_t      wmask;
	reg_idx_t    rd;
	funct3_t     funct3;
	logic [11:0] csr_addr;
	logic        redirect, reg_wen, load_en, store_en, csr_en, link_en, ecall;

	`include "exu_ref_model.svh"

	expect_t exp_q[$];
	int      cycles = 0;
	int      issued, retired;
	logic    last_in_fire, last_out_valid, last_out_ready;

	exu_top dut (.*);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycle) begin
			$display("timeout: only %0d of %0d results seen after %0d cycles",
				retired, n_inst, cycles);
			stop_fail();
		end
	end

	task automatic stop_fail();
		$display("TEST FAIL");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_mask(input string name, input wmask_t got, input wmask_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_funct3(input string name, input funct3_t got, input funct3_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_csr_addr(input string name, input logic [11:0] got,
		input logic [11:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_reset_state();
		check_flag("in_ready", in_ready, 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("redirect", redirect, 1'b0);
	endtask

	// random legal instruction with rd and rs1 below 16
	task automatic make_inst(output word_t w);
		word_t   r, kind;
		funct3_t f3;
		draw_bits(32, r);
		draw_bits(4, kind);
		f3 = r[14:12];
		w  = r & 32'hfff7_f7ff;
		case (kind % 11)
			0: w[6:0] = opc_lui;
			1: w[6:0] = opc_auipc;
			2: w[6:0] = opc_jal;
			3: begin
				w[14:12] = 3'b000;
				w[6:0]   = opc_jalr;
			end
			4: begin
				w[14:12] = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3; // no 010, 011
				w[6:0]   = opc_branch;
			end
			5: begin
				w[14:12] = (f3 == 3'd3 || f3 > 3'd5) ? {2'b00, f3[0]} : f3;
				w[6:0]   = opc_load;
			end
			6: begin
				w[14:12] = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
				w[6:0]   = opc_store;
			end
			7: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					w[31:25] = {1'b0, r[30] && f3 == 3'd5, 5'b0};
				w[6:0] = opc_op_imm;
			end
			8: begin
				w[31:24] = {1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 6'b0};
				w[6:0]   = opc_op;
			end
			9: begin
				w[14:12] = f3[0] ? 3'b001 : 3'b010; // csrrw or csrrs
				w[6:0]   = opc_system;
			end
			default: w = r[0] ? 32'h0000_0073 : 32'h3020_0073; // ecall or mret
		endcase
	endtask

	task automatic present_next();
		word_t r;
		make_inst(inst);
		draw_bits(32, pc);
		pc[1:0] = 2'b00;
		draw_bits(32, src1);
		draw_bits(32, src2);
		draw_bits(32, csr_val);
		draw_bits(32, csr_jump);
		draw_bits(3, r);
		csr_jump_en = (r == 0); // rare redirect
		in_valid    = 1'b1;
		issued++;
	endtask

	// called at the falling edge with every signal settled
	task automatic monitor_cycle();
		logic    exp_valid;
		expect_t e;
		exp_valid = (last_out_valid && !last_out_ready) || last_in_fire;
		check_flag("out_valid", out_valid, exp_valid);
		check_flag("in_ready", in_ready, !exp_valid);
		if (!out_valid) begin
			check_flag("redirect", redirect, 1'b0);
		end else if (exp_q.size() == 0) begin
			$display("result presented with no accepted instruction behind it");
			stop_fail();
		end else begin
			e = exp_q[0];
			check_word("val", val, e.val);
			check_word("jump_addr", jump_addr, e.jump_addr);
			check_word("csr_wdata", csr_wdata, e.csr_wdata);
			check_word("store_data", store_data, e.store_data);
			check_word("pc_out", pc_out, e.pc_out);
			check_mask("wmask", wmask, e.wmask);
			check_idx("rd", rd, e.rd);
			check_funct3("funct3", funct3, e.funct3);
			check_csr_addr("csr_addr", csr_addr, e.csr_addr);
			check_flag("redirect", redirect, e.redirect);
			check_flag("reg_wen", reg_wen, e.reg_wen);
			check_flag("load_en", load_en, e.load_en);
			check_flag("store_en", store_en, e.store_en);
			check_flag("csr_en", csr_en, e.csr_en);
			check_flag("link_en", link_en, e.link_en);
			check_flag("ecall", ecall, e.ecall);
			if (out_ready) begin
				exp_q.delete(0);
				retired++;
			end
		end
		if (in_valid && in_ready)
			exp_q.push_back(model_expect(inst, pc, src1, src2, csr_val, csr_jump_en, csr_jump));
		last_in_fire   = in_valid && in_ready;
		last_out_valid = out_valid;
		last_out_ready = out_ready;
	endtask

	initial begin
		word_t r;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		out_ready   = 1'b0;
		inst        = '0;
		pc          = '0;
		src1        = '0;
		src2        = '0;
		csr_val     = '0;
		csr_jump    = '0;
		csr_jump_en = 1'b0;
		issued      = 0;
		retired     = 0;
		last_in_fire   = 1'b0;
		last_out_valid = 1'b0;
		last_out_ready = 1'b0;
		repeat (5) begin
			@(posedge clock);
			#1;
			check_reset_state();
		end
		rst_n = 1'b1;
		@(posedge clock);
		#1;
		check_reset_state();
		while (retired < n_inst) begin
			if (!in_valid && issued < n_inst)
				present_next();
			draw_bits(3, r);
			out_ready = (r >= 3); // low on 3 of 8 cycles
			@(negedge clock);
			monitor_cycle();
			@(posedge clock);
			#1;
			if (last_in_fire)
				in_valid = 1'b0;
		end
		if (exp_q.size() != 0 || issued != n_inst) begin
			$display("%0d results left over at end of run", exp_q.size());
			stop_fail();
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+tests
hdl/exu_pkg.sv
hdl/decoded_if.sv
hdl/exec_if.sv
hdl/inst_decode.sv
hdl/exec_unit.sv
hdl/result_buffer.sv
hdl/exu_top.sv
tests/tb_exu.sv

/* Bender.yml */
package:
  name: exu

sources:
  - files:
      - hdl/exu_pkg.sv
      - hdl/decoded_if.sv
      - hdl/exec_if.sv
      - hdl/inst_decode.sv
      - hdl/exec_unit.sv
      - hdl/result_buffer.sv
      - hdl/exu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_exu.sv
